// ==== vlog.f ====
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/regfile.sv
verilog/pipe_reg.sv
verilog/instr_decode.sv
verilog/instr_exec.sv
verilog/multi_cycle_exec.sv
verilog/cpu_core.sv
dv/tb_cpu_core.sv

// ==== dv/tb_cpu_core.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_defines.svh"

module tb_cpu_core;

localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_ADDIU   = 6'h09;
localparam logic [5:0] OP_ORI     = 6'h0d;
localparam logic [5:0] OP_LUI     = 6'h0f;
localparam logic [5:0] F_MFHI     = 6'h10;
localparam logic [5:0] F_MFLO     = 6'h12;
localparam logic [5:0] F_MULTU    = 6'h19;
localparam logic [5:0] F_DIVU     = 6'h1b;
localparam logic [5:0] F_ADDU     = 6'h21;
localparam logic [5:0] F_SUBU     = 6'h23;
localparam logic [5:0] F_AND      = 6'h24;
localparam logic [5:0] F_OR       = 6'h25;
localparam logic [5:0] F_XOR      = 6'h26;
localparam logic [5:0] F_SLT      = 6'h2a;

localparam int NUM_ALU   = 200;
localparam int NUM_CHAIN = 60;
localparam int NUM_ZERO  = 10;
localparam int NUM_MDU   = 16;
localparam int NUM_BP    = 10;
localparam int NUM_INSTR = NUM_ALU + NUM_CHAIN + 4 * NUM_ZERO + 7 * NUM_MDU + 8 * NUM_BP;
// twice the worst case of 4 cycles per instruction plus the port stall of each mdu op
localparam int TIMEOUT_CYCLES = 2 * (4 * NUM_INSTR + (`MDU_ITER + 2) * (NUM_MDU + NUM_BP)) + 100;

logic clk;
logic rst;
logic instr_valid_i;
logic [31:0] instr_i;
logic instr_ready_o;
logic commit_valid_o;
logic [4:0] commit_rd_o;
logic [31:0] commit_data_o;

int seed;
int err_count;
int test_count;
int test_err_start;
int cycle_count;
int exp_count;
int commit_count;

// reference model state
logic [31:0] mregs [32];
logic [31:0] mhi;
logic [31:0] mlo;
int mdu_block;
logic exp_v1;
logic exp_v2;
logic [4:0] exp_rd1;
logic [4:0] exp_rd2;
logic [31:0] exp_data1;
logic [31:0] exp_data2;

cpu_core u_dut (
	.clk            ( clk            ),
	.rst            ( rst            ),
	.instr_valid_i  ( instr_valid_i  ),
	.instr_i        ( instr_i        ),
	.instr_ready_o  ( instr_ready_o  ),
	.commit_valid_o ( commit_valid_o ),
	.commit_rd_o    ( commit_rd_o    ),
	.commit_data_o  ( commit_data_o  )
);

always #5 clk = ~clk;

function automatic int rand_below(input int n);
	return $unsigned($random(seed)) % n;
endfunction

function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
	return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// sel 9 and above passes the raw word through as a mostly unsupported encoding
function automatic logic [31:0] alu_word(input int sel, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [31:0] rnd);
	case (sel)
		0: return rtype(F_ADDU, rs, rt, rd);
		1: return rtype(F_SUBU, rs, rt, rd);
		2: return rtype(F_AND, rs, rt, rd);
		3: return rtype(F_OR, rs, rt, rd);
		4: return rtype(F_XOR, rs, rt, rd);
		5: return rtype(F_SLT, rs, rt, rd);
		6: return itype(OP_ADDIU, rs, rd, rnd[15:0]);
		7: return itype(OP_ORI, rs, rd, rnd[15:0]);
		8: return itype(OP_LUI, 5'd0, rd, rnd[15:0]);
		default: return rnd;
	endcase
endfunction

task automatic model_step(input logic [31:0] w, output logic [4:0] rd,
		output logic [31:0] res, output logic is_mdu);
	logic [31:0] a;
	logic [31:0] b;
	logic [63:0] prod;
	a = mregs[w[25:21]];
	b = mregs[w[20:16]];
	rd = '0;
	res = '0;
	is_mdu = 1'b0;
	if (w[31:26] == OP_SPECIAL) begin
		rd = w[15:11];
		case (w[5:0])
			F_ADDU: res = a + b;
			F_SUBU: res = a - b;
			F_AND:  res = a & b;
			F_OR:   res = a | b;
			F_XOR:  res = a ^ b;
			F_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F_MFHI: res = mhi;
			F_MFLO: res = mlo;
			F_MULTU: begin
				prod = {32'd0, a} * {32'd0, b};
				{mhi, mlo} = prod;
				rd = '0;
				is_mdu = 1'b1;
			end
			F_DIVU: begin
				mlo = (b == 0) ? 32'hffff_ffff : a / b;
				mhi = (b == 0) ? a : a % b;
				rd = '0;
				is_mdu = 1'b1;
			end
			default: rd = '0;
		endcase
	end else if (w[31:26] == OP_ADDIU) begin
		rd = w[20:16];
		res = a + {{16{w[15]}}, w[15:0]};
	end else if (w[31:26] == OP_ORI) begin
		rd = w[20:16];
		res = a | {16'd0, w[15:0]};
	end else if (w[31:26] == OP_LUI) begin
		rd = w[20:16];
		res = {w[15:0], 16'd0};
	end
	if (rd != '0) begin
		mregs[rd] = res;
	end
endtask

// model advances on every accepted instruction and expects its commit two edges later
always @(posedge clk) begin
	logic [4:0] rd;
	logic [31:0] res;
	logic is_mdu;
	if (rst) begin
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		mhi = '0;
		mlo = '0;
		exp_count = 0;
		commit_count = 0;
		exp_v1 <= 1'b0;
		exp_v2 <= 1'b0;
		mdu_block <= 0;
	end else begin
		exp_v2 <= exp_v1;
		exp_rd2 <= exp_rd1;
		exp_data2 <= exp_data1;
		exp_v1 <= 1'b0;
		if (mdu_block != 0) begin
			mdu_block <= mdu_block - 1;
		end
		if (commit_valid_o) begin
			commit_count++;
		end
		if (instr_valid_i && instr_ready_o) begin
			model_step(instr_i, rd, res, is_mdu);
			exp_v1 <= rd != '0;
			exp_rd1 <= rd;
			exp_data1 <= res;
			if (rd != '0) begin
				exp_count++;
			end
			// one cycle in EX plus the iterations and the final update
			if (is_mdu) begin
				mdu_block <= `MDU_ITER + 2;
			end
		end
	end
end

a_commit_timing: assert property (@(negedge clk) disable iff (rst)
	commit_valid_o == exp_v2)
	else begin
		$display("MISMATCH %0t commit_valid_o got %b expected %b", $time, commit_valid_o, exp_v2);
		err_count++;
	end

a_commit_rd: assert property (@(negedge clk) disable iff (rst)
	(commit_valid_o && exp_v2) |-> commit_rd_o == exp_rd2)
	else begin
		$display("MISMATCH %0t commit_rd_o got %0d expected %0d", $time, commit_rd_o, exp_rd2);
		err_count++;
	end

a_commit_data: assert property (@(negedge clk) disable iff (rst)
	(commit_valid_o && exp_v2) |-> commit_data_o == exp_data2)
	else begin
		$display("MISMATCH %0t commit_data_o got %h expected %h", $time, commit_data_o,
			exp_data2);
		err_count++;
	end

a_ready_timing: assert property (@(negedge clk) disable iff (rst)
	instr_ready_o == (mdu_block == 0))
	else begin
		$display("MISMATCH %0t instr_ready_o got %b expected %b", $time, instr_ready_o,
			mdu_block == 0);
		err_count++;
	end

task automatic idle(input int n);
	repeat (n) begin
		instr_valid_i <= 1'b0;
		instr_i <= $random(seed);
		@(posedge clk);
	end
endtask

task automatic issue(input logic [31:0] word);
	instr_valid_i <= 1'b1;
	instr_i <= word;
	@(posedge clk);
	// held steady until the core takes it
	while (!instr_ready_o) begin
		@(posedge clk);
	end
	instr_valid_i <= 1'b0;
endtask

task automatic load_reg(input logic [4:0] r, input logic [31:0] val);
	issue(itype(OP_LUI, 5'd0, r, val[31:16]));
	issue(itype(OP_ORI, r, r, val[15:0]));
endtask

task automatic report_test(input string name);
	idle(4);
	assert (commit_count == exp_count)
	else begin
		$display("MISMATCH %0t commit_count in %s got %0d expected %0d", $time, name,
			commit_count, exp_count);
		err_count++;
	end
	test_count++;
	$display("test %s done with %0d errors", name, err_count - test_err_start);
	test_err_start = err_count;
endtask

task automatic reset_check();
	idle(3);
	assert (instr_ready_o === 1'b1)
	else begin
		$display("MISMATCH %0t instr_ready_o got %b expected %b", $time, instr_ready_o,
			1'b1);
		err_count++;
	end
	report_test("reset");
endtask

task automatic random_alu();
	for (int i = 0; i < NUM_ALU; i++) begin
		issue(alu_word(rand_below(10), rand_below(32), rand_below(32), rand_below(32),
			$random(seed)));
		idle(rand_below(3));
	end
	report_test("random_alu");
endtask

// rs hits the EX result and rt the one in WB
task automatic dep_chain();
	logic [4:0] prev;
	logic [4:0] prev2;
	logic [4:0] rd;
	prev = 1 + rand_below(31);
	prev2 = 1 + rand_below(31);
	for (int i = 0; i < NUM_CHAIN; i++) begin
		rd = 1 + rand_below(31);
		issue(alu_word(rand_below(8), prev, prev2, rd, $random(seed)));
		prev2 = prev;
		prev = rd;
		if (rand_below(4) == 0) begin
			idle(1);
		end
	end
	report_test("dep_chain");
endtask

task automatic zero_reg();
	for (int i = 0; i < NUM_ZERO; i++) begin
		issue(itype(OP_ADDIU, rand_below(32), 5'd0, $random(seed)));
		issue(rtype(F_ADDU, rand_below(32), rand_below(32), 5'd0));
		issue(rtype(F_OR, 5'd0, 5'd0, 1 + rand_below(31)));
		issue(itype(OP_ADDIU, 5'd0, 1 + rand_below(31), $random(seed)));
	end
	report_test("reg_zero");
endtask

// odd iterations divide and every fourth divisor is zero
task automatic mdu_ops();
	logic [4:0] ra;
	logic [4:0] rb;
	logic [31:0] a;
	logic [31:0] b;
	for (int i = 0; i < NUM_MDU; i++) begin
		ra = 1 + rand_below(31);
		rb = (ra % 31) + 1;
		a = $random(seed);
		b = $random(seed);
		if (i % 4 == 1) begin
			b = b >> 20;
		end else if (i % 4 == 3) begin
			b = '0;
		end
		load_reg(ra, a);
		load_reg(rb, b);
		issue(rtype((i % 2 == 1) ? F_DIVU : F_MULTU, ra, rb, 5'd0));
		issue(rtype(F_MFHI, 5'd0, 5'd0, 1 + rand_below(31)));
		issue(rtype(F_MFLO, 5'd0, 5'd0, 1 + rand_below(31)));
	end
	report_test("mdu");
endtask

// instructions queue up at the port right behind each mdu op
task automatic back_pressure();
	for (int i = 0; i < NUM_BP; i++) begin
		issue(rtype(rand_below(2) ? F_DIVU : F_MULTU, rand_below(32), rand_below(32),
			rand_below(32)));
		for (int k = 0; k < 6; k++) begin
			issue(alu_word(rand_below(9), rand_below(32), rand_below(32), rand_below(32),
				$random(seed)));
		end
		issue(rtype(F_MFLO, 5'd0, 5'd0, 1 + rand_below(31)));
	end
	report_test("back_pressure");
endtask

initial begin
	cycle_count = 0;
	while (cycle_count < TIMEOUT_CYCLES) begin
		@(posedge clk);
		cycle_count++;
	end
	$display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
	$display("Simulation finished: FAIL");
	$finish;
end

initial begin
	seed = 32'hd933085a;
	err_count = 0;
	test_count = 0;
	test_err_start = 0;
	clk = 1'b0;
	rst <= 1'b1;
	instr_valid_i <= 1'b0;
	instr_i <= '0;
	repeat (4) @(posedge clk);
	rst <= 1'b0;
	reset_check();
	random_alu();
	dep_chain();
	zero_reg();
	mdu_ops();
	back_pressure();
	$display("tests run: %0d, errors: %0d, commits: %0d", test_count, err_count, commit_count);
	if (err_count == 0) begin
		$display("Simulation finished: PASS");
	end else begin
		$display("Simulation finished: FAIL");
	end
	$finish;
end

endmodule

`default_nettype wire

// ==== verilog/cpu_core.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_defines.svh"

module cpu_core
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      instr_valid_i,
	input  uint32_t   instr_i,
	output logic      instr_ready_o,
	output logic      commit_valid_o,
	output reg_addr_t commit_rd_o,
	output uint32_t   commit_data_o
);

// register file
reg_addr_t [1:0] reg_raddr;
uint32_t   [1:0] reg_rdata;

// pipeline data
pipeline_decode_t pipeline_decode;
pipeline_decode_t pipeline_decode_d;
pipeline_wb_t     pipeline_exec;
pipeline_wb_t     pipeline_wb;

// multiply/divide unit
mdu_req_t mdu_req;
hilo_t    mdu_hilo;
logic     mdu_busy;

// hold the port while an mdu op is in EX or still iterating
assign instr_ready_o = !(mdu_req.start || mdu_busy);

regfile #(
	.DATA_WIDTH ( `DATA_WIDTH ),
	.READ_PORTS ( 2           )
) regfile_inst (
	.clk,
	.rst,
	.we_i    ( pipeline_wb.valid ),
	.waddr_i ( pipeline_wb.rd    ),
	.wdata_i ( pipeline_wb.wdata ),
	.raddr_i ( reg_raddr         ),
	.rdata_o ( reg_rdata         )
);

instr_decode decode_inst (
	.instr_valid_i,
	.instr_i,
	.reg_raddr_o ( reg_raddr       ),
	.reg_rdata_i ( reg_rdata       ),
	.ex_fwd_i    ( pipeline_exec   ),
	.wb_fwd_i    ( pipeline_wb     ),
	.decode_o    ( pipeline_decode )
);

// pipeline between ID and EX, bubble while not ready
pipe_reg #(
	.T ( pipeline_decode_t )
) id_ex_reg (
	.clk,
	.rst,
	.stall_i ( 1'b0              ),
	.flush_i ( !instr_ready_o    ),
	.d_i     ( pipeline_decode   ),
	.q_o     ( pipeline_decode_d )
);

instr_exec exec_inst (
	.decode_i  ( pipeline_decode_d ),
	.hilo_i    ( mdu_hilo          ),
	.mdu_req_o ( mdu_req           ),
	.result_o  ( pipeline_exec     )
);

multi_cycle_exec multi_cycle_exec_inst (
	.clk,
	.rst,
	.req_i  ( mdu_req  ),
	.busy_o ( mdu_busy ),
	.hilo_o ( mdu_hilo )
);

// pipeline between EX and WB
pipe_reg #(
	.T ( pipeline_wb_t )
) ex_wb_reg (
	.clk,
	.rst,
	.stall_i ( 1'b0          ),
	.flush_i ( 1'b0          ),
	.d_i     ( pipeline_exec ),
	.q_o     ( pipeline_wb   )
);

// write back doubles as commit
assign commit_valid_o = pipeline_wb.valid && pipeline_wb.rd != '0;
assign commit_rd_o    = pipeline_wb.rd;
assign commit_data_o  = pipeline_wb.wdata;

endmodule

`default_nettype wire

// ==== verilog/multi_cycle_exec.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_defines.svh"

module multi_cycle_exec
	import cpu_pipe_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  mdu_req_t req_i,
	output logic     busy_o,
	output hilo_t    hilo_o
);

localparam int DW = `DATA_WIDTH;
localparam int CNT_W = $clog2(`MDU_ITER + 1);
localparam logic [CNT_W-1:0] ITER_LAST = CNT_W'(`MDU_ITER - 1);

typedef enum logic [1:0] {
	IDLE,
	RUN,
	DONE
} mdu_state_t;

mdu_state_t state;
logic [CNT_W-1:0] iter_cnt;
hilo_t hilo_q;

// working registers, loaded on start
logic is_div_q;
logic [DW-1:0] operand_q;
logic [DW-1:0] work_hi;
logic [DW-1:0] work_lo;

logic [DW:0] mul_sum;
logic [DW:0] div_shift;
logic [DW:0] div_diff;
logic [DW-1:0] next_hi;
logic [DW-1:0] next_lo;

always_ff @(posedge clk) begin
	if (rst) begin
		state    <= IDLE;
		iter_cnt <= '0;
		hilo_q   <= '0;
	end else begin
		case (state)
			IDLE: begin
				if (req_i.start) begin
					state    <= RUN;
					iter_cnt <= '0;
				end
			end
			RUN: begin
				iter_cnt <= iter_cnt + 1'b1;
				if (iter_cnt == ITER_LAST) begin
					state <= DONE;
				end
			end
			DONE: begin
				hilo_q.hi <= work_hi;
				hilo_q.lo <= work_lo;
				state     <= IDLE;
			end
			default: state <= IDLE;
		endcase
	end
end

// multiplicand or divisor stays in operand_q, lo holds multiplier or dividend
always_ff @(posedge clk) begin
	if (state == IDLE && req_i.start) begin
		is_div_q  <= req_i.is_div;
		operand_q <= req_i.is_div ? req_i.op_b : req_i.op_a;
		work_hi   <= '0;
		work_lo   <= req_i.is_div ? req_i.op_a : req_i.op_b;
	end else if (state == RUN) begin
		work_hi <= next_hi;
		work_lo <= next_lo;
	end
end

always_comb begin
	mul_sum   = {1'b0, work_hi} + (work_lo[0] ? {1'b0, operand_q} : '0);
	div_shift = {work_hi, work_lo[DW-1]};
	div_diff  = div_shift - {1'b0, operand_q};
	if (is_div_q) begin
		// restoring step, zero divisor always subtracts
		if (div_shift >= {1'b0, operand_q}) begin
			next_hi = div_diff[DW-1:0];
			next_lo = {work_lo[DW-2:0], 1'b1};
		end else begin
			next_hi = div_shift[DW-1:0];
			next_lo = {work_lo[DW-2:0], 1'b0};
		end
	end else begin
		{next_hi, next_lo} = {mul_sum, work_lo[DW-1:1]};
	end
end

assign busy_o = state != IDLE;
assign hilo_o = hilo_q;

a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
	req_i.start |-> !busy_o);

a_cnt_range: assert property (@(posedge clk) disable iff (rst)
	iter_cnt <= CNT_W'(`MDU_ITER));

endmodule

`default_nettype wire

// ==== verilog/instr_exec.sv ====
`default_nettype none
`timescale 1ns/100ps

module instr_exec
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  pipeline_decode_t decode_i,
	input  hilo_t            hilo_i,
	output mdu_req_t         mdu_req_o,
	output pipeline_wb_t     result_o
);

uint32_t op_a;
uint32_t op_b;
uint32_t alu_out;
alu_op_t alu_op;
logic is_mdu;

assign alu_op = decode_i.decoded.alu_op;
assign op_a   = decode_i.op_a;
assign op_b   = decode_i.decoded.use_imm ? decode_i.decoded.imm : decode_i.op_b;

always_comb begin
	case (alu_op)
		ALU_ADD:  alu_out = op_a + op_b;
		ALU_SUB:  alu_out = op_a - op_b;
		ALU_AND:  alu_out = op_a & op_b;
		ALU_OR:   alu_out = op_a | op_b;
		ALU_XOR:  alu_out = op_a ^ op_b;
		ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
		ALU_LUI:  alu_out = decode_i.decoded.imm << 16;
		ALU_MFHI: alu_out = hilo_i.hi;
		ALU_MFLO: alu_out = hilo_i.lo;
		default:  alu_out = '0;
	endcase
end

// MULTU and DIVU retire here with rd zero, the unit finishes on its own
assign is_mdu = alu_op == ALU_MULTU || alu_op == ALU_DIVU;

assign mdu_req_o.start  = decode_i.valid && is_mdu;
assign mdu_req_o.is_div = alu_op == ALU_DIVU;
assign mdu_req_o.op_a   = decode_i.op_a;
assign mdu_req_o.op_b   = decode_i.op_b;

assign result_o.valid = decode_i.valid;
assign result_o.rd    = decode_i.decoded.rd;
assign result_o.wdata = alu_out;

endmodule

`default_nettype wire

// ==== verilog/instr_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

module instr_decode
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic             instr_valid_i,
	input  uint32_t          instr_i,
	output reg_addr_t [1:0]  reg_raddr_o,
	input  uint32_t   [1:0]  reg_rdata_i,
	input  pipeline_wb_t     ex_fwd_i,
	input  pipeline_wb_t     wb_fwd_i,
	output pipeline_decode_t decode_o
);

logic [5:0] opcode;
logic [5:0] funct;
logic [15:0] imm16;
decoded_instr_t dec;
reg_addr_t [1:0] src;
uint32_t [1:0] operand;

assign opcode = instr_i[31:26];
assign funct  = instr_i[5:0];
assign imm16  = instr_i[15:0];

always_comb begin
	dec    = '0;
	dec.rs = instr_i[25:21];
	dec.rt = instr_i[20:16];
	case (opcode)
		OPC_SPECIAL: begin
			case (funct)
				FN_ADDU:  dec.alu_op = ALU_ADD;
				FN_SUBU:  dec.alu_op = ALU_SUB;
				FN_AND:   dec.alu_op = ALU_AND;
				FN_OR:    dec.alu_op = ALU_OR;
				FN_XOR:   dec.alu_op = ALU_XOR;
				FN_SLT:   dec.alu_op = ALU_SLT;
				FN_MFHI:  dec.alu_op = ALU_MFHI;
				FN_MFLO:  dec.alu_op = ALU_MFLO;
				FN_MULTU: dec.alu_op = ALU_MULTU;
				FN_DIVU:  dec.alu_op = ALU_DIVU;
				default:  dec.alu_op = ALU_NOP;
			endcase
			// mdu ops and unknown functions write no register
			if (dec.alu_op != ALU_NOP && dec.alu_op != ALU_MULTU && dec.alu_op != ALU_DIVU) begin
				dec.rd = instr_i[15:11];
			end
		end
		OPC_ADDIU: begin
			dec.alu_op  = ALU_ADD;
			dec.rd      = instr_i[20:16];
			dec.use_imm = 1'b1;
			dec.imm     = {{16{imm16[15]}}, imm16};
		end
		OPC_ORI: begin
			dec.alu_op  = ALU_OR;
			dec.rd      = instr_i[20:16];
			dec.use_imm = 1'b1;
			dec.imm     = {16'b0, imm16};
		end
		OPC_LUI: begin
			dec.alu_op  = ALU_LUI;
			dec.rd      = instr_i[20:16];
			dec.use_imm = 1'b1;
			dec.imm     = {16'b0, imm16};
		end
		default: dec.alu_op = ALU_NOP;
	endcase
end

assign src[0] = dec.rs;
assign src[1] = dec.rt;
assign reg_raddr_o = src;

// newest result wins
always_comb begin
	for (int i = 0; i < 2; i++) begin
		if (src[i] == '0) begin
			operand[i] = '0;
		end else if (ex_fwd_i.valid && ex_fwd_i.rd == src[i]) begin
			operand[i] = ex_fwd_i.wdata;
		end else if (wb_fwd_i.valid && wb_fwd_i.rd == src[i]) begin
			operand[i] = wb_fwd_i.wdata;
		end else begin
			operand[i] = reg_rdata_i[i];
		end
	end
end

assign decode_o.valid   = instr_valid_i;
assign decode_o.decoded = dec;
assign decode_o.op_a    = operand[0];
assign decode_o.op_b    = operand[1];

endmodule

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
`default_nettype none
`timescale 1ns/100ps

module pipe_reg #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst,
	input  logic stall_i,
	input  logic flush_i,
	input  T     d_i,
	output T     q_o
);

// all zeros is a bubble since valid is cleared
always_ff @(posedge clk) begin
	if (rst || flush_i) begin
		q_o <= '0;
	end else if (!stall_i) begin
		q_o <= d_i;
	end
end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_defines.svh"

module regfile
	import cpu_isa_pkg::*;
#(
	parameter int DATA_WIDTH = `DATA_WIDTH,
	parameter int READ_PORTS = 2
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       we_i,
	input  reg_addr_t                  waddr_i,
	input  uint32_t                    wdata_i,
	input  reg_addr_t [READ_PORTS-1:0] raddr_i,
	output uint32_t   [READ_PORTS-1:0] rdata_o
);

logic [DATA_WIDTH-1:0] regs [`REG_NUM];

// register 0 is never written, so it stays zero after reset
always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `REG_NUM; i++) begin
			regs[i] <= '0;
		end
	end else if (we_i && waddr_i != '0) begin
		regs[waddr_i] <= wdata_i;
	end
end

for (genvar i = 0; i < READ_PORTS; i++) begin : gen_read
	assign rdata_o[i] = regs[raddr_i[i]];
end

a_waddr_known: assert property (@(posedge clk) disable iff (rst)
	we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

// ==== verilog/cpu_pipe_pkg.sv ====
`default_nettype none

package cpu_pipe_pkg;

import cpu_isa_pkg::*;

// ID/EX payload, operands already forwarded
typedef struct packed {
	logic           valid;
	decoded_instr_t decoded;
	uint32_t        op_a;
	uint32_t        op_b;
} pipeline_decode_t;

// EX/WB payload, also used as forwarding source
typedef struct packed {
	logic      valid;
	reg_addr_t rd;
	uint32_t   wdata;
} pipeline_wb_t;

// start is a single cycle strobe
typedef struct packed {
	logic    start;
	logic    is_div;
	uint32_t op_a;
	uint32_t op_b;
} mdu_req_t;

typedef struct packed {
	uint32_t hi;
	uint32_t lo;
} hilo_t;

endpackage

`default_nettype wire

// ==== verilog/cpu_isa_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_isa_pkg;

typedef logic [`DATA_WIDTH-1:0] uint32_t;
typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;

typedef enum logic [3:0] {
	ALU_NOP,
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_SLT,
	ALU_LUI,
	ALU_MFHI,
	ALU_MFLO,
	ALU_MULTU,
	ALU_DIVU
} alu_op_t;

// primary opcodes
localparam logic [5:0] OPC_SPECIAL = 6'b000000;
localparam logic [5:0] OPC_ADDIU   = 6'b001001;
localparam logic [5:0] OPC_ORI     = 6'b001101;
localparam logic [5:0] OPC_LUI     = 6'b001111;

// function field of SPECIAL
localparam logic [5:0] FN_MFHI  = 6'b010000;
localparam logic [5:0] FN_MFLO  = 6'b010010;
localparam logic [5:0] FN_MULTU = 6'b011001;
localparam logic [5:0] FN_DIVU  = 6'b011011;
localparam logic [5:0] FN_ADDU  = 6'b100001;
localparam logic [5:0] FN_SUBU  = 6'b100011;
localparam logic [5:0] FN_AND   = 6'b100100;
localparam logic [5:0] FN_OR    = 6'b100101;
localparam logic [5:0] FN_XOR   = 6'b100110;
localparam logic [5:0] FN_SLT   = 6'b101010;

// rd is zero when nothing is written back
typedef struct packed {
	alu_op_t   alu_op;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic      use_imm;
	uint32_t   imm;
} decoded_instr_t;

endpackage

`default_nettype wire

// ==== verilog/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// general purpose register count
`define REG_NUM 32

// data path width in bits
`define DATA_WIDTH 32

// one iteration per operand bit
`define MDU_ITER 32

`endif
